/* cam_bridge_pkg.sv */
package cam_bridge_pkg;

	////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////

	// Device write strobe fields
	typedef logic [7:0]  dev_index_t;
	typedef logic [7:0]  dev_cmd_t;
	typedef logic [31:0] dev_wdata_t;

	// Backlight duty and its 12-bit PWM counter
	typedef logic [7:0]  pwm_duty_t;
	typedef logic [11:0] pwm_count_t;

	// One CSI receive word, four RAW8 pixels
	typedef logic [31:0] pixel_t;

	// Frame starts seen by the monitor
	typedef logic [3:0]  frame_count_t;

	////////////////////////////////////////////////////////////
	// Device register map
	////////////////////////////////////////////////////////////

	// Only one device index is decoded
	localparam dev_index_t REG_INDEX_MAIN  = 8'h00;

	// Commands under the main index
	localparam dev_cmd_t   CMD_FLASH_EN    = 8'h00;
	localparam dev_cmd_t   CMD_PATTERN_SEL = 8'h01;
	localparam dev_cmd_t   CMD_PWM_DUTY    = 8'h03;

	////////////////////////////////////////////////////////////
	// Test pattern timing
	////////////////////////////////////////////////////////////

	// Horizontal, in clock cycles
	localparam int PAT_H_ACTIVE = 32;
	localparam int PAT_H_TOTAL  = 40;

	// Vertical, in lines; 12 x 40 gives a 480-cycle frame
	localparam int PAT_V_ACTIVE = 8;
	localparam int PAT_V_TOTAL  = 12;

	// LED follows this frame counter bit
	localparam int LED_FRAME_BIT = 3;

endpackage

/* dev_reg_block.sv */
module dev_reg_block (
	input  logic                       w_csi_rx_clk,
	input  logic                       w_sys_rstn,

	// Single-cycle write strobe, no back-pressure
	input  logic                       dev_wvalid_i,
	input  cam_bridge_pkg::dev_index_t dev_index_i,
	input  cam_bridge_pkg::dev_cmd_t   dev_cmd_i,
	input  cam_bridge_pkg::dev_wdata_t dev_wdata_i,

	// Settings
	output logic                       flash_en_o,
	output cam_bridge_pkg::pwm_duty_t  pwm_duty_o,
	output logic                       pattern_sel_o
);
	import cam_bridge_pkg::*;

	// Setting registers
	logic      r_flash_en;
	pwm_duty_t r_pwm_duty;
	logic      r_pattern_sel;

	// Strobe aimed at the main index
	logic      w_main_wr;

	assign w_main_wr = dev_wvalid_i && (dev_index_i == REG_INDEX_MAIN);

	// Load on the strobe edge
	// Value visible the cycle after
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			// Flash off, backlight off, camera stream
			r_flash_en    <= 1'b0;
			r_pwm_duty    <= '0;
			r_pattern_sel <= 1'b0;
		end else if (w_main_wr) begin
			case (dev_cmd_i)
				// Hand the quad-SPI pins to the flash master
				CMD_FLASH_EN:    r_flash_en    <= dev_wdata_i[0];
				// 1 selects the internal test pattern
				CMD_PATTERN_SEL: r_pattern_sel <= dev_wdata_i[0];
				// Low byte is the backlight duty
				CMD_PWM_DUTY:    r_pwm_duty    <= dev_wdata_i[7:0];
				// Unknown command, nothing changes
				default: ;
			endcase
		end
	end

	assign flash_en_o    = r_flash_en;
	assign pwm_duty_o    = r_pwm_duty;
	assign pattern_sel_o = r_pattern_sel;

endmodule

/* backlight_pwm.sv */
module backlight_pwm (
	input  logic                      w_csi_rx_clk,
	input  logic                      w_sys_rstn,

	// Duty in 1/256 steps
	input  cam_bridge_pkg::pwm_duty_t pwm_duty_i,

	// Backlight enable to the panel
	output logic                      pwm_o
);
	import cam_bridge_pkg::*;

	// Free-running period counter, 4096 cycles
	pwm_count_t r_pwm_cnt;

	// Duty scaled to the counter range
	pwm_count_t w_threshold;

	// Registered compare result
	logic       r_pwm;

	// Duty x 16, so 255 still leaves a short low time
	assign w_threshold = {pwm_duty_i, 4'b0000};

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			r_pwm_cnt <= '0;
			r_pwm     <= 1'b0;
		end else begin
			// Wraps at 4095
			r_pwm_cnt <= r_pwm_cnt + 1'b1;
			// Duty 0 never exceeds the count, so the backlight stays off
			r_pwm     <= (w_threshold > r_pwm_cnt);
		end
	end

	// One cycle behind the compare
	assign pwm_o = r_pwm;

endmodule

/* flash_pin_mux.sv */
module flash_pin_mux (
	// Owner select, 1 gives the pins to the flash master
	input  logic       flash_en_i,

	// Quad-SPI flash master
	input  logic       spi_ssn_i,
	input  logic       spi_sck_i,
	input  logic [3:0] spi_d_o_i,
	input  logic [3:0] spi_d_oe_i,

	// Sensor I2C master
	input  logic       i2c_scl_i,
	input  logic       i2c_sda_o_i,
	input  logic       i2c_sda_oe_i,

	// Pad inputs
	input  logic [3:0] pad_d_i,

	// Pad outputs
	output logic       spi_cs_o,
	output logic       spi_sck_o,
	output logic       spi_sck_oe_o,
	output logic [3:0] pad_d_o,
	output logic [3:0] pad_d_oe_o,

	// Returns to the masters
	output logic [3:0] spi_d_i_o,
	output logic       i2c_sda_i_o
);

	// Pad view of the I2C master
	// D0 = SCL, D1 = SDA, D2 = WPn, D3 = HOLDn
	logic [3:0] w_i2c_d_o;
	logic [3:0] w_i2c_d_oe;

	// SCL is push-pull from the master
	// WPn and HOLDn held inactive
	assign w_i2c_d_o  = {1'b1, 1'b1, i2c_sda_o_i, i2c_scl_i};
	assign w_i2c_d_oe = {1'b1, 1'b1, i2c_sda_oe_i, 1'b1};

	////////////////////////////////////////////////////////////
	// Output steering
	////////////////////////////////////////////////////////////

	// Flash deselected while I2C owns the pins
	assign spi_cs_o     = flash_en_i ? spi_ssn_i : 1'b1;

	// Clock pad parked low when not in flash use
	assign spi_sck_o    = flash_en_i ? spi_sck_i : 1'b0;
	assign spi_sck_oe_o = 1'b1;

	// Data pads
	assign pad_d_o      = flash_en_i ? spi_d_o_i  : w_i2c_d_o;
	assign pad_d_oe_o   = flash_en_i ? spi_d_oe_i : w_i2c_d_oe;

	////////////////////////////////////////////////////////////
	// Input return
	////////////////////////////////////////////////////////////

	// Flash master always sees the pads
	assign spi_d_i_o    = pad_d_i;

	// SDA reads back from D1 in either mode
	assign i2c_sda_i_o  = pad_d_i[1];

endmodule

/* pattern_frame_gen.sv */
module pattern_frame_gen (
	input  logic                   w_csi_rx_clk,
	input  logic                   w_sys_rstn,

	// Synthetic camera stream
	output logic                   pat_vsync_o,
	output logic                   pat_href_o,
	output cam_bridge_pkg::pixel_t pat_data_o
);
	import cam_bridge_pkg::*;

	////////////////////////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////////////////////////

	// Cycle within the line, 0 to 39
	logic [$clog2(PAT_H_TOTAL)-1:0] r_h_cnt;

	// Line within the frame, 0 to 11
	logic [$clog2(PAT_V_TOTAL)-1:0] r_v_cnt;

	// Last cycle of a line / last line of a frame
	logic w_h_last;
	logic w_v_last;

	assign w_h_last = (int'(r_h_cnt) == PAT_H_TOTAL - 1);
	assign w_v_last = (int'(r_v_cnt) == PAT_V_TOTAL - 1);

	// Free-running from reset
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			r_h_cnt <= '0;
			r_v_cnt <= '0;
		end else begin
			if (w_h_last) begin
				r_h_cnt <= '0;
				// Step the line at the end of each line
				if (w_v_last) begin
					r_v_cnt <= '0;
				end else begin
					r_v_cnt <= r_v_cnt + 1'b1;
				end
			end else begin
				r_h_cnt <= r_h_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Valid signals and pixel word
	////////////////////////////////////////////////////////////

	// Frame valid over lines 0 to 7
	logic   w_frame_valid;

	// Line valid over cycles 0 to 31 of an active line
	logic   w_line_valid;

	// Word counter, cleared in blanking
	pixel_t r_pat_data;

	assign w_frame_valid = (int'(r_v_cnt) < PAT_V_ACTIVE);
	assign w_line_valid  = w_frame_valid && (int'(r_h_cnt) < PAT_H_ACTIVE);

	// Holds 0 on the first active cycle, +1 per active cycle
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			r_pat_data <= '0;
		end else if (w_line_valid) begin
			r_pat_data <= r_pat_data + 1'b1;
		end else begin
			r_pat_data <= '0;
		end
	end

	// Decoded straight from the counters, aligned with the word
	assign pat_vsync_o = w_frame_valid;
	assign pat_href_o  = w_line_valid;
	assign pat_data_o  = r_pat_data;

endmodule

/* frame_monitor.sv */
module frame_monitor (
	input  logic                   w_csi_rx_clk,
	input  logic                   w_sys_rstn,

	// 0 camera, 1 test pattern
	input  logic                   pattern_sel_i,

	// Camera stream from the CSI receiver
	input  logic                   cam_vsync_i,
	input  logic                   cam_href_i,
	input  cam_bridge_pkg::pixel_t cam_data_i,

	// Internal test pattern
	input  logic                   pat_vsync_i,
	input  logic                   pat_href_i,
	input  cam_bridge_pkg::pixel_t pat_data_i,

	// Retimed stream
	output logic                   frame_vsync_o,
	output logic                   frame_href_o,
	output cam_bridge_pkg::pixel_t frame_data_o,

	// Heartbeat, toggles every 8 frames
	output logic                   led_o
);
	import cam_bridge_pkg::*;

	// Source select
	logic         w_sel_vsync;
	logic         w_sel_href;
	pixel_t       w_sel_data;

	// Retiming stage
	logic         r_vsync;
	logic         r_href;
	pixel_t       r_data;

	// Vsync history for rising-edge detect
	logic [1:0]   r_vsync_sr;
	frame_count_t r_frame_cnt;

	assign w_sel_vsync = pattern_sel_i ? pat_vsync_i : cam_vsync_i;
	assign w_sel_href  = pattern_sel_i ? pat_href_i  : cam_href_i;
	assign w_sel_data  = pattern_sel_i ? pat_data_i  : cam_data_i;

	// Control bits and frame counter
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			r_vsync     <= 1'b0;
			r_href      <= 1'b0;
			r_vsync_sr  <= 2'b00;
			r_frame_cnt <= '0;
		end else begin
			r_vsync    <= w_sel_vsync;
			r_href     <= w_sel_href;
			r_vsync_sr <= {r_vsync_sr[0], w_sel_vsync};
			// Count once per frame start
			if (r_vsync_sr == 2'b01) begin
				r_frame_cnt <= r_frame_cnt + 1'b1;
			end
		end
	end

	// Pixel word, qualified by href downstream
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			r_data <= '0;
		end else begin
			r_data <= w_sel_data;
		end
	end

	assign frame_vsync_o = r_vsync;
	assign frame_href_o  = r_href;
	assign frame_data_o  = r_data;
	assign led_o         = r_frame_cnt[LED_FRAME_BIT];

endmodule

/* cam_bridge_top.sv */
module cam_bridge_top (
	input  logic                       w_csi_rx_clk,
	input  logic                       w_sys_rstn,

	// Device register writes
	input  logic                       dev_wvalid_i,
	input  cam_bridge_pkg::dev_index_t dev_index_i,
	input  cam_bridge_pkg::dev_cmd_t   dev_cmd_i,
	input  cam_bridge_pkg::dev_wdata_t dev_wdata_i,

	// Panel backlight
	output logic                       pwm_o,

	// Flash master side
	input  logic                       spi_ssn_i,
	input  logic                       spi_sck_i,
	input  logic [3:0]                 spi_d_o_i,
	input  logic [3:0]                 spi_d_oe_i,
	output logic [3:0]                 spi_d_i_o,

	// Sensor I2C master side
	input  logic                       i2c_scl_i,
	input  logic                       i2c_sda_o_i,
	input  logic                       i2c_sda_oe_i,
	output logic                       i2c_sda_i_o,

	// Shared pads
	input  logic [3:0]                 pad_d_i,
	output logic                       spi_cs_o,
	output logic                       spi_sck_o,
	output logic                       spi_sck_oe_o,
	output logic [3:0]                 pad_d_o,
	output logic [3:0]                 pad_d_oe_o,

	// Camera stream in, selected stream out
	input  logic                       cam_vsync_i,
	input  logic                       cam_href_i,
	input  cam_bridge_pkg::pixel_t     cam_data_i,
	output logic                       frame_vsync_o,
	output logic                       frame_href_o,
	output cam_bridge_pkg::pixel_t     frame_data_o,
	output logic                       led_o
);

	////////////////////////////////////////////////////////////
	// Settings
	////////////////////////////////////////////////////////////

	logic                      w_flash_en;
	cam_bridge_pkg::pwm_duty_t w_pwm_duty;
	logic                      w_pattern_sel;

	dev_reg_block u_dev_reg_block (
		.w_csi_rx_clk  (w_csi_rx_clk),
		.w_sys_rstn    (w_sys_rstn),
		.dev_wvalid_i  (dev_wvalid_i),
		.dev_index_i   (dev_index_i),
		.dev_cmd_i     (dev_cmd_i),
		.dev_wdata_i   (dev_wdata_i),
		.flash_en_o    (w_flash_en),
		.pwm_duty_o    (w_pwm_duty),
		.pattern_sel_o (w_pattern_sel)
	);

	// Backlight
	backlight_pwm u_backlight_pwm (
		.w_csi_rx_clk (w_csi_rx_clk),
		.w_sys_rstn   (w_sys_rstn),
		.pwm_duty_i   (w_pwm_duty),
		.pwm_o        (pwm_o)
	);

	// Flash / I2C pin sharing
	flash_pin_mux u_flash_pin_mux (
		.flash_en_i   (w_flash_en),
		.spi_ssn_i    (spi_ssn_i),
		.spi_sck_i    (spi_sck_i),
		.spi_d_o_i    (spi_d_o_i),
		.spi_d_oe_i   (spi_d_oe_i),
		.i2c_scl_i    (i2c_scl_i),
		.i2c_sda_o_i  (i2c_sda_o_i),
		.i2c_sda_oe_i (i2c_sda_oe_i),
		.pad_d_i      (pad_d_i),
		.spi_cs_o     (spi_cs_o),
		.spi_sck_o    (spi_sck_o),
		.spi_sck_oe_o (spi_sck_oe_o),
		.pad_d_o      (pad_d_o),
		.pad_d_oe_o   (pad_d_oe_o),
		.spi_d_i_o    (spi_d_i_o),
		.i2c_sda_i_o  (i2c_sda_i_o)
	);

	////////////////////////////////////////////////////////////
	// Frame path
	////////////////////////////////////////////////////////////

	logic                   w_pat_vsync;
	logic                   w_pat_href;
	cam_bridge_pkg::pixel_t w_pat_data;

	pattern_frame_gen u_pattern_frame_gen (
		.w_csi_rx_clk (w_csi_rx_clk),
		.w_sys_rstn   (w_sys_rstn),
		.pat_vsync_o  (w_pat_vsync),
		.pat_href_o   (w_pat_href),
		.pat_data_o   (w_pat_data)
	);

	frame_monitor u_frame_monitor (
		.w_csi_rx_clk  (w_csi_rx_clk),
		.w_sys_rstn    (w_sys_rstn),
		.pattern_sel_i (w_pattern_sel),
		.cam_vsync_i   (cam_vsync_i),
		.cam_href_i    (cam_href_i),
		.cam_data_i    (cam_data_i),
		.pat_vsync_i   (w_pat_vsync),
		.pat_href_i    (w_pat_href),
		.pat_data_i    (w_pat_data),
		.frame_vsync_o (frame_vsync_o),
		.frame_href_o  (frame_href_o),
		.frame_data_o  (frame_data_o),
		.led_o         (led_o)
	);

endmodule

/* tb_cam_bridge.sv */
module tb_cam_bridge;
	import cam_bridge_pkg::*;

	// Six PWM windows plus about 26 frames, with margin
	localparam int TIMEOUT_CYCLES     = 60000;
	// Pattern raster and LED rate
	localparam int EXP_LINE_WORDS     = 32;
	localparam int EXP_FRAME_LINES    = 8;
	localparam int EXP_FRAMES_PER_LED = 8;

	////////////////////////////////////////////////////////////
	// DUT signals
	////////////////////////////////////////////////////////////

	logic       w_csi_rx_clk = 1'b0;
	logic       w_sys_rstn;
	logic       dev_wvalid_i;
	dev_index_t dev_index_i;
	dev_cmd_t   dev_cmd_i;
	dev_wdata_t dev_wdata_i;
	logic       pwm_o;
	// Flash master and I2C master side
	logic       spi_ssn_i;
	logic       spi_sck_i;
	logic [3:0] spi_d_o_i;
	logic [3:0] spi_d_oe_i;
	logic [3:0] spi_d_i_o;
	logic       i2c_scl_i;
	logic       i2c_sda_o_i;
	logic       i2c_sda_oe_i;
	logic       i2c_sda_i_o;
	// Shared pads
	logic [3:0] pad_d_i;
	logic [3:0] pad_d_o;
	logic [3:0] pad_d_oe_o;
	logic       spi_cs_o;
	logic       spi_sck_o;
	logic       spi_sck_oe_o;
	// Camera in, frame out
	logic       cam_vsync_i;
	logic       cam_href_i;
	pixel_t     cam_data_i;
	logic       frame_vsync_o;
	logic       frame_href_o;
	logic       led_o;
	pixel_t     frame_data_o;

	// Bookkeeping
	int         cycle_cnt = 0;
	int         err_cnt = 0;
	int         check_cnt = 0;
	int         test_cnt = 0;
	int         test_bad_cnt = 0;
	int         test_err_base;
	string      test_name;
	// 0 idle, 1 pin mux, 2 camera retime
	int         cmp_mode = 0;
	logic       flash_en_exp = 1'b0;
	logic       prev_vsync;
	logic       prev_href;
	pixel_t     prev_data;

	cam_bridge_top dut (.*);

	always #20 w_csi_rx_clk = ~w_csi_rx_clk;

	// Hard stop
	always @(posedge w_csi_rx_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout, run stopped after %0d cycles in test %s", cycle_cnt, test_name);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// High cycles per 4096-cycle window
	function automatic int pwm_high_ref(input pwm_duty_t duty);
		return int'(duty) * 16;
	endfunction

	// Pin mux outputs as {cs, sck, sck_oe, d_o, d_oe, d_i, sda_i}
	function automatic logic [15:0] mux_ref(input logic en);
		logic       cs;
		logic       sck;
		logic [3:0] d_o;
		logic [3:0] d_oe;
		if (en) begin
			cs   = spi_ssn_i;
			sck  = spi_sck_i;
			d_o  = spi_d_o_i;
			d_oe = spi_d_oe_i;
		end else begin
			// Flash deselected, clock parked low
			cs      = 1'b1;
			sck     = 1'b0;
			// SCL on D0, always driven
			d_o[0]  = i2c_scl_i;
			d_oe[0] = 1'b1;
			// SDA on D1 with the master's enable
			d_o[1]  = i2c_sda_o_i;
			d_oe[1] = i2c_sda_oe_i;
			// WPn and HOLDn high
			d_o[3:2]  = 2'b11;
			d_oe[3:2] = 2'b11;
		end
		return {cs, sck, 1'b1, d_o, d_oe, pad_d_i, pad_d_i[1]};
	endfunction

	// Word count within a line
	function automatic pixel_t pat_word_ref(input int idx);
		return pixel_t'(idx);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h (cycle %0d)", name, got, exp, cycle_cnt);
			err_cnt++;
		end
	endtask

	// Compare process, outputs are stable at the falling edge
	always @(negedge w_csi_rx_clk) begin : compare_proc
		logic [15:0] exp_mux;
		if (cmp_mode == 1) begin
			exp_mux = mux_ref(flash_en_exp);
			check_val("spi_cs_o", spi_cs_o, exp_mux[15]);
			check_val("spi_sck_o", spi_sck_o, exp_mux[14]);
			check_val("spi_sck_oe_o", spi_sck_oe_o, exp_mux[13]);
			check_val("pad_d_o", pad_d_o, exp_mux[12:9]);
			check_val("pad_d_oe_o", pad_d_oe_o, exp_mux[8:5]);
			check_val("spi_d_i_o", spi_d_i_o, exp_mux[4:1]);
			check_val("i2c_sda_i_o", i2c_sda_i_o, exp_mux[0]);
		end else if (cmp_mode == 2) begin
			check_val("frame_vsync_o", frame_vsync_o, prev_vsync);
			check_val("frame_href_o", frame_href_o, prev_href);
			check_val("frame_data_o", frame_data_o, prev_data);
		end
		// Camera inputs seen now appear one cycle later
		prev_vsync = cam_vsync_i;
		prev_href  = cam_href_i;
		prev_data  = cam_data_i;
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	task automatic open_test(input string name);
		test_cnt++;
		test_name     = name;
		test_err_base = err_cnt;
	endtask

	task automatic close_test;
		if (err_cnt == test_err_base) begin
			$display("Test %0d %s: passed", test_cnt, test_name);
		end else begin
			$display("Test %0d %s: %0d errors", test_cnt, test_name, err_cnt - test_err_base);
			test_bad_cnt++;
		end
	endtask

	// One-cycle write strobe
	task automatic write_reg(input dev_index_t idx, input dev_cmd_t cmd, input dev_wdata_t data);
		@(posedge w_csi_rx_clk);
		dev_wvalid_i <= 1'b1;
		dev_index_i  <= idx;
		dev_cmd_i    <= cmd;
		dev_wdata_i  <= data;
		@(posedge w_csi_rx_clk);
		dev_wvalid_i <= 1'b0;
	endtask

	task automatic drive_pins_random;
		@(posedge w_csi_rx_clk);
		spi_ssn_i    <= 1'($urandom);
		spi_sck_i    <= 1'($urandom);
		spi_d_o_i    <= 4'($urandom);
		spi_d_oe_i   <= 4'($urandom);
		i2c_scl_i    <= 1'($urandom);
		i2c_sda_o_i  <= 1'($urandom);
		i2c_sda_oe_i <= 1'($urandom);
		pad_d_i      <= 4'($urandom);
	endtask

	// Walks one whole frame from its first active cycle
	task automatic check_pattern_frame;
		int lines;
		int words;
		@(negedge w_csi_rx_clk);
		while (frame_vsync_o) @(negedge w_csi_rx_clk);
		while (!frame_vsync_o) @(negedge w_csi_rx_clk);
		lines = 0;
		words = 0;
		while (frame_vsync_o) begin
			if (frame_href_o) begin
				check_val("frame_data_o", frame_data_o, pat_word_ref(words));
				words++;
			end else if (words != 0) begin
				// End of an active line
				check_val("href cycles per line", words, EXP_LINE_WORDS);
				lines++;
				words = 0;
			end
			@(negedge w_csi_rx_clk);
		end
		check_val("lines per frame", lines, EXP_FRAME_LINES);
	endtask

	// Rising edges of frame_vsync_o until led_o changes
	task automatic count_frames_per_toggle(output int rises);
		logic led_start;
		logic vs_last;
		rises = 0;
		@(negedge w_csi_rx_clk);
		led_start = led_o;
		vs_last   = frame_vsync_o;
		do begin
			@(negedge w_csi_rx_clk);
			if (frame_vsync_o && !vs_last) rises++;
			vs_last = frame_vsync_o;
		end while (led_o == led_start);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		pwm_duty_t duty_list [6];
		int        high_cnt;
		int        rises;
		void'($urandom(74149));
		w_sys_rstn   <= 1'b0;
		dev_wvalid_i <= 1'b0;
		dev_index_i  <= '0;
		dev_cmd_i    <= '0;
		dev_wdata_i  <= '0;
		// Low chip select from the master shows up if flash were enabled
		spi_ssn_i    <= 1'b0;
		spi_sck_i    <= 1'b0;
		spi_d_o_i    <= '0;
		spi_d_oe_i   <= '0;
		i2c_scl_i    <= 1'b0;
		i2c_sda_o_i  <= 1'b0;
		i2c_sda_oe_i <= 1'b0;
		pad_d_i      <= '0;
		cam_vsync_i  <= 1'b0;
		cam_href_i   <= 1'b0;
		cam_data_i   <= '0;
		repeat (16) @(posedge w_csi_rx_clk);
		w_sys_rstn <= 1'b1;

		open_test("reset and unknown writes");
		@(negedge w_csi_rx_clk);
		check_val("pwm_o", pwm_o, 1'b0);
		check_val("led_o", led_o, 1'b0);
		check_val("frame_href_o", frame_href_o, 1'b0);
		check_val("spi_cs_o", spi_cs_o, 1'b1);
		write_reg(REG_INDEX_MAIN, 8'h02, 32'hffff_ffff);
		write_reg(8'h05, CMD_FLASH_EN, 32'hffff_ffff);
		write_reg(8'h05, CMD_PWM_DUTY, 32'h0000_00ff);
		write_reg(8'h05, CMD_PATTERN_SEL, 32'h0000_0001);
		repeat (300) begin
			@(negedge w_csi_rx_clk);
			check_val("pwm_o", pwm_o, 1'b0);
			check_val("spi_cs_o", spi_cs_o, 1'b1);
			check_val("frame_href_o", frame_href_o, 1'b0);
		end
		close_test;

		open_test("backlight duty");
		duty_list[0] = 8'd0;
		duty_list[1] = 8'd255;
		for (int i = 2; i < 6; i++) duty_list[i] = 8'($urandom);
		foreach (duty_list[i]) begin
			// Junk in the upper data bits must be ignored
			write_reg(REG_INDEX_MAIN, CMD_PWM_DUTY, {24'($urandom), duty_list[i]});
			@(posedge w_csi_rx_clk);
			high_cnt = 0;
			repeat (4096) begin
				@(negedge w_csi_rx_clk);
				if (pwm_o) high_cnt++;
			end
			check_val("pwm_o high count", high_cnt, pwm_high_ref(duty_list[i]));
		end
		close_test;

		open_test("flash pin sharing");
		@(posedge w_csi_rx_clk);
		cmp_mode = 1;
		repeat (64) drive_pins_random;
		write_reg(REG_INDEX_MAIN, CMD_FLASH_EN, 32'h0000_0001);
		flash_en_exp = 1'b1;
		repeat (64) drive_pins_random;
		@(posedge w_csi_rx_clk);
		cmp_mode = 0;
		close_test;

		open_test("test pattern raster");
		write_reg(REG_INDEX_MAIN, CMD_PATTERN_SEL, 32'h0000_0001);
		// Retimed stream now comes from the pattern
		@(posedge w_csi_rx_clk);
		repeat (2) check_pattern_frame;
		close_test;

		open_test("camera retime");
		write_reg(REG_INDEX_MAIN, CMD_PATTERN_SEL, 32'h0000_0000);
		@(posedge w_csi_rx_clk);
		cmp_mode = 2;
		repeat (200) begin
			@(posedge w_csi_rx_clk);
			cam_vsync_i <= 1'($urandom);
			cam_href_i  <= 1'($urandom);
			cam_data_i  <= $urandom;
		end
		// Last camera word leaves the retiming stage
		repeat (2) @(posedge w_csi_rx_clk);
		cmp_mode = 0;
		close_test;

		open_test("frame LED");
		write_reg(REG_INDEX_MAIN, CMD_PATTERN_SEL, 32'h0000_0001);
		// First toggle only aligns to the counter
		count_frames_per_toggle(rises);
		repeat (2) begin
			count_frames_per_toggle(rises);
			check_val("frames per led_o toggle", rises, EXP_FRAMES_PER_LED);
		end
		close_test;

		$display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors, %0d cycles",
			test_cnt, test_bad_cnt, check_cnt, err_cnt, cycle_cnt);
		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
cam_bridge_pkg.sv
dev_reg_block.sv
backlight_pwm.sv
flash_pin_mux.sv
pattern_frame_gen.sv
frame_monitor.sv
cam_bridge_top.sv
tb_cam_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for the result
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary -Wno-fatal --top-module tb_cam_bridge -f filelist.f \
	-o sim_cam_bridge > build.log 2>&1 \
	&& ./obj_dir/sim_cam_bridge > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "^ALL CHECKS PASSED$" sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
